//--- logic/uart_line_pkg.sv
// UART line package: frame constants, byte and divisor types, FSM state encodings
package uart_line_pkg;

    // one data byte on the line
    typedef logic [7 : 0] uart_byte_t;

    // run-time baud divisor, a bit lasts comp+1 clocks
    typedef logic [15 : 0] baud_div_t;

    // start, eight data bits, stop
    localparam int FRAME_BITS = 10;

    // receiver FSM
    typedef enum logic [0 : 0]
    {
        RX_IDLE,    // waiting for a falling edge
        RX_FRAME    // sampling a frame
    } rx_state_t;

    // transmitter FSM
    typedef enum logic [0 : 0]
    {
        TX_IDLE,    // line high, may pop the FIFO
        TX_FRAME    // shifting a frame out
    } tx_state_t;

endpackage : uart_line_pkg

//--- logic/uart_buf_pkg.sv
// UART buffer package: FIFO depth with pointer and fill count types
package uart_buf_pkg;

    // entries in the echo FIFO
    localparam int FIFO_DEPTH = 8;

    // read and write pointers wrap naturally at FIFO_DEPTH
    typedef logic [$clog2(FIFO_DEPTH) - 1 : 0] fifo_ptr_t;

    // one extra bit so that a full buffer can be counted
    typedef logic [$clog2(FIFO_DEPTH) : 0] fifo_cnt_t;

endpackage : uart_buf_pkg

//--- logic/uart_receiver.sv
// UART receiver: mid-bit sampling of the serial input with a stop bit check
`timescale 1ns/1ns

module uart_receiver
    import uart_line_pkg::*;
(
    input   logic           clk,
    input   logic           resetn,
    input   logic           en,         // holds the FSM idle when low
    input   baud_div_t      comp,       // baud divisor
    input   logic           uart_rx,    // serial input
    output  uart_byte_t     rx_data,    // valid while rx_valid is high
    output  logic           rx_valid,   // one cycle per good frame
    output  logic           frame_err   // one cycle per bad stop bit
);

    rx_state_t                  state;
    rx_state_t                  next_state;
    baud_div_t                  counter;        // clocks within current bit
    logic   [3 : 0]             bit_counter;    // bit index within frame
    logic   [FRAME_BITS-2 : 0]  shift_reg;      // stop bit and data, start shifted out
    logic                       rx_prev;        // line value of last cycle
    logic                       start_edge;
    logic                       bit_end;
    logic                       mid_bit;
    logic                       frame_end;

    assign start_edge = rx_prev && !uart_rx;
    assign bit_end    = counter >= comp;
    assign mid_bit    = counter == (comp >> 1);
    assign frame_end  = (state == RX_FRAME) && bit_end
                        && (bit_counter == 4'(FRAME_BITS - 1));

    assign rx_data = shift_reg[7 : 0];

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state <= RX_IDLE;
        else if (!en)
            state <= RX_IDLE;   // abandon any partial frame
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            RX_IDLE  : if (start_edge) next_state = RX_FRAME;
            RX_FRAME : if (frame_end)  next_state = RX_IDLE;
            default  :                 next_state = RX_IDLE;
        endcase
    end

    // edge detector for the start bit
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            rx_prev <= 1'b1;
        else
            rx_prev <= uart_rx;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            counter     <= '0;
            bit_counter <= '0;
            rx_valid    <= 1'b0;
            frame_err   <= 1'b0;
        end
        else
        begin
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
            if (!en || state == RX_IDLE)
            begin
                // the edge cycle is already count 0 of the start bit
                counter     <= (en && start_edge) ? baud_div_t'(1) : '0;
                bit_counter <= '0;
            end
            else
            begin
                if (bit_end)
                begin
                    counter     <= '0;
                    bit_counter <= bit_counter + 1'b1;
                end
                else
                    counter <= counter + 1'b1;
                if (frame_end)
                begin
                    rx_valid  <= shift_reg[FRAME_BITS-2];   // stop bit sampled high
                    frame_err <= !shift_reg[FRAME_BITS-2];
                end
            end
        end
    end

    // mid-bit samples enter at the top, LSB ends up at bit 0
    always_ff @(posedge clk)
    begin
        if (en && state == RX_FRAME && mid_bit)
            shift_reg <= {uart_rx, shift_reg[FRAME_BITS-2 : 1]};
    end

    a_rx_exclusive : assert property (
        @(posedge clk) disable iff (!resetn) !(rx_valid && frame_err)
    );

    // frames are at least ten bit periods apart
    a_rx_single_pulse : assert property (
        @(posedge clk) disable iff (!resetn) rx_valid |=> !rx_valid
    );

endmodule : uart_receiver

//--- logic/byte_fifo.sv
// Byte FIFO with eight entries, a synchronous flush and overflow indication
`timescale 1ns/1ns

module byte_fifo
    import uart_line_pkg::*;
    import uart_buf_pkg::*;
(
    input   logic           clk,
    input   logic           resetn,
    input   logic           flush,      // synchronous clear
    input   logic           wr,         // write strobe
    input   uart_byte_t     wr_data,
    input   logic           pop,        // read strobe that advances the head
    output  uart_byte_t     rd_data,    // head entry
    output  logic           empty,
    output  logic           full,
    output  logic           overflow    // write dropped this cycle
);

    uart_byte_t     mem [FIFO_DEPTH];
    fifo_ptr_t      wr_ptr;
    fifo_ptr_t      rd_ptr;
    fifo_cnt_t      count;
    logic           do_wr;
    logic           do_pop;

    assign empty    = count == '0;
    assign full     = count == fifo_cnt_t'(FIFO_DEPTH);
    assign do_wr    = wr && !full;
    assign do_pop   = pop && !empty;
    assign overflow = wr && full;
    assign rd_data  = mem[rd_ptr];

    // byte storage
    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_pop})
                2'b10   : count <= count + 1'b1;
                2'b01   : count <= count - 1'b1;
                default : count <= count;   // neither or both at once
            endcase
        end
    end

    // the transmitter must only pop while it sees data
    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (!resetn) pop |-> !empty
    );

endmodule : byte_fifo

//--- logic/uart_transmitter.sv
// UART transmitter: pops bytes from the FIFO when idle and shifts them out LSB first
`timescale 1ns/1ns

module uart_transmitter
    import uart_line_pkg::*;
(
    input   logic           clk,
    input   logic           resetn,
    input   logic           en,         // holds the FSM idle when low
    input   logic           tx_pause,   // no new frames while high
    input   baud_div_t      comp,       // baud divisor
    input   logic           empty,      // FIFO has nothing to send
    input   uart_byte_t     tx_byte,    // FIFO head, valid with pop
    output  logic           pop,        // one cycle read strobe
    output  logic           uart_tx     // serial output
);

    tx_state_t                  state;
    baud_div_t                  counter;        // clocks within current bit
    logic   [3 : 0]             bit_counter;    // bits already sent
    logic   [FRAME_BITS-1 : 0]  frame_reg;      // bit 0 is on the line
    logic                       bit_end;
    logic                       frame_end;
    logic                       can_pop;

    assign bit_end   = counter >= comp;
    assign frame_end = bit_end && (bit_counter == 4'(FRAME_BITS - 1));
    // pop is a pulse, so it must not repeat while the load is pending
    assign can_pop   = (state == TX_IDLE) && !empty && !tx_pause && !pop;

    assign uart_tx = frame_reg[0];

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state       <= TX_IDLE;
            counter     <= '0;
            bit_counter <= '0;
            frame_reg   <= '1;
            pop         <= 1'b0;
        end
        else if (!en)
        begin
            state       <= TX_IDLE;     // line back to mark
            counter     <= '0;
            bit_counter <= '0;
            frame_reg   <= '1;
            pop         <= 1'b0;
        end
        else
        begin
            pop <= can_pop;
            case (state)
                TX_IDLE :
                begin
                    if (pop)
                    begin
                        frame_reg   <= {1'b1, tx_byte, 1'b0};   // stop, data, start
                        counter     <= '0;
                        bit_counter <= '0;
                        state       <= TX_FRAME;
                    end
                end
                TX_FRAME :
                begin
                    if (bit_end)
                    begin
                        counter     <= '0;
                        bit_counter <= bit_counter + 1'b1;
                        frame_reg   <= {1'b1, frame_reg[FRAME_BITS-1 : 1]}; // fill with mark
                        if (frame_end)
                            state <= TX_IDLE;
                    end
                    else
                        counter <= counter + 1'b1;
                end
                default : state <= TX_IDLE;
            endcase
        end
    end

    // after ten shifts the frame register is all ones again
    a_idle_mark : assert property (
        @(posedge clk) disable iff (!resetn) (state == TX_IDLE) |-> uart_tx
    );

endmodule : uart_transmitter

//--- logic/uart_echo.sv
// UART echo top level where the receiver feeds the byte FIFO and the transmitter drains it
`timescale 1ns/1ns

module uart_echo
    import uart_line_pkg::*;
(
    input   logic           clk,
    input   logic           resetn,
    input   logic           en,         // path enable that flushes the FIFO when low
    input   logic           tx_pause,   // clear-to-send style hold
    input   baud_div_t      comp,       // baud divisor shared by both directions
    input   logic           uart_rx,
    output  logic           uart_tx,
    output  uart_byte_t     rx_data,
    output  logic           rx_valid,
    output  logic           frame_err,
    output  logic           overflow
);

    uart_byte_t     fifo_data;
    logic           fifo_empty;
    logic           fifo_pop;
    logic           fifo_flush;

    assign fifo_flush = !en;

    uart_receiver rx_unit
    (
        .clk        ( clk        ),
        .resetn     ( resetn     ),
        .en         ( en         ),
        .comp       ( comp       ),
        .uart_rx    ( uart_rx    ),
        .rx_data    ( rx_data    ),
        .rx_valid   ( rx_valid   ),
        .frame_err  ( frame_err  )
    );

    // buffer between receiver and transmitter
    byte_fifo buf_unit
    (
        .clk        ( clk        ),
        .resetn     ( resetn     ),
        .flush      ( fifo_flush ),
        .wr         ( rx_valid   ),
        .wr_data    ( rx_data    ),
        .pop        ( fifo_pop   ),
        .rd_data    ( fifo_data  ),
        .empty      ( fifo_empty ),
        .full       (            ),
        .overflow   ( overflow   )
    );

    uart_transmitter tx_unit
    (
        .clk        ( clk        ),
        .resetn     ( resetn     ),
        .en         ( en         ),
        .tx_pause   ( tx_pause   ),
        .comp       ( comp       ),
        .empty      ( fifo_empty ),
        .tx_byte    ( fifo_data  ),
        .pop        ( fifo_pop   ),
        .uart_tx    ( uart_tx    )
    );

endmodule : uart_echo

//--- verification/uart_serial_model.svh
// UART serial model: line driver, uart_tx decoder and expected echo queue
`ifndef UART_SERIAL_MODEL_SVH
`define UART_SERIAL_MODEL_SVH

uart_byte_t echo_q[$];      // bytes still expected on uart_tx
uart_byte_t decoded_q[$];   // bytes seen on uart_tx, not yet compared

// drives one frame on uart_rx, called right after a falling edge
task automatic send_frame(input uart_byte_t data, input logic bad_stop);
    logic [FRAME_BITS-1 : 0] bits;
    int gap;
    bits = {!bad_stop, data, 1'b0};             // stop, data, start
    gap  = int'(comp) + 1 + $urandom % (int'(comp) + 1);
    for (int i = 0; i < FRAME_BITS; i++)
    begin
        uart_rx = bits[i];
        repeat (int'(comp) + 1) @(negedge clk);
    end
    uart_rx = 1'b1;                             // idle at least one bit period
    repeat (gap) @(negedge clk);
endtask

// finds each start bit on uart_tx and samples every bit in its middle
task automatic decode_tx_line();
    uart_byte_t data;
    logic stop_bit;
    forever
    begin
        @(negedge clk);
        if (uart_tx === 1'b0)
        begin
            repeat (int'(comp) / 2) @(negedge clk);     // middle of start bit
            for (int i = 0; i < 8; i++)
            begin
                repeat (int'(comp) + 1) @(negedge clk);
                data[i] = uart_tx;                      // lsb first
            end
            repeat (int'(comp) + 1) @(negedge clk);
            stop_bit = uart_tx;
            if (stop_bit !== 1'b1)
            begin
                $display("Stop bit on uart_tx was not high for byte %02h", data);
                other_errors++;
            end
            decoded_q.push_back(data);
        end
    end
endtask

`endif

//--- verification/uart_echo_tb.sv
// UART echo testbench driving random frames and checking receiver pulses and echoed bytes
`timescale 1ns/1ns

module uart_echo_tb
    import uart_line_pkg::*;
    import uart_buf_pkg::*;
();

    logic           clk = 1'b0;
    logic           resetn;
    logic           en;
    logic           tx_pause;
    baud_div_t      comp;
    logic           uart_rx;
    logic           uart_tx;
    uart_byte_t     rx_data;
    logic           rx_valid;
    logic           frame_err;
    logic           overflow;

    int             mismatch_errors = 0;
    int             other_errors = 0;
    int             valid_cnt = 0;      // pulses seen by the monitor
    int             ferr_cnt = 0;
    int             ovf_cnt = 0;
    int             held = 0;           // model of bytes parked in the FIFO
    uart_byte_t     rx_q[$];            // bytes shown with rx_valid

    `include "uart_serial_model.svh"

    uart_echo UUT
    (
        .clk        ( clk       ),
        .resetn     ( resetn    ),
        .en         ( en        ),
        .tx_pause   ( tx_pause  ),
        .comp       ( comp      ),
        .uart_rx    ( uart_rx   ),
        .uart_tx    ( uart_tx   ),
        .rx_data    ( rx_data   ),
        .rx_valid   ( rx_valid  ),
        .frame_err  ( frame_err ),
        .overflow   ( overflow  )
    );

    always #50 clk = ~clk;

    // counts result pulses and keeps each byte shown with rx_valid
    always @(negedge clk)
    begin
        if (rx_valid)
        begin
            valid_cnt++;
            rx_q.push_back(rx_data);
        end
        if (frame_err)
            ferr_cnt++;
        if (overflow)
            ovf_cnt++;
    end

    initial decode_tx_line();

    task automatic check_byte(input string name, input uart_byte_t expected,
                              input uart_byte_t actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s: expected %02h, actual %02h", name, expected, actual);
            mismatch_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s: expected %0b, actual %0b", name, expected, actual);
            mismatch_errors++;
        end
    endtask

    // sends one frame and checks the receiver's answer to it
    task automatic receive_frame(input string name, input uart_byte_t data,
                                 input logic bad_stop);
        int v0;
        int f0;
        int o0;
        int waited;
        int limit;
        logic drop;
        uart_byte_t got;
        v0 = valid_cnt;
        f0 = ferr_cnt;
        o0 = ovf_cnt;
        limit = 4 * (int'(comp) + 1);
        drop = !bad_stop && tx_pause && (held >= FIFO_DEPTH);
        send_frame(data, bad_stop);
        waited = 0;
        while (valid_cnt == v0 && ferr_cnt == f0 && waited < limit)
        begin
            @(negedge clk);
            waited++;
        end
        if (valid_cnt == v0 && ferr_cnt == f0)
        begin
            $display("Timeout waiting for rx_valid or frame_err in %s", name);
            other_errors++;
        end
        check_flag({name, " frame_err"}, bad_stop, ferr_cnt != f0);
        check_flag({name, " rx_valid"}, !bad_stop, valid_cnt != v0);
        check_flag({name, " overflow"}, drop, ovf_cnt != o0);
        if (!bad_stop && rx_q.size() > 0)
        begin
            got = rx_q.pop_front();
            check_byte({name, " rx_data"}, data, got);
        end
        rx_q.delete();
        if (!bad_stop && !drop)
        begin
            echo_q.push_back(data);
            if (tx_pause)
                held++;     // stays in the FIFO until release
        end
    endtask

    // compares echoed bytes until the model queue is empty, then expects silence
    task automatic drain_echo(input string name);
        int limit;
        int waited;
        uart_byte_t got;
        uart_byte_t want;
        limit = (echo_q.size() + 2) * 12 * (int'(comp) + 1);
        waited = 0;
        while (echo_q.size() > 0 && waited < limit)
        begin
            @(negedge clk);
            waited++;
            while (decoded_q.size() > 0 && echo_q.size() > 0)
            begin
                got  = decoded_q.pop_front();
                want = echo_q.pop_front();
                check_byte(name, want, got);
            end
        end
        if (echo_q.size() > 0)
        begin
            $display("Timeout waiting for %0d echoed bytes in %s", echo_q.size(), name);
            other_errors++;
            echo_q.delete();
        end
        repeat (12 * (int'(comp) + 1)) @(negedge clk);
        if (decoded_q.size() > 0)
        begin
            $display("%0d bytes echoed that should not have been, in %s",
                     decoded_q.size(), name);
            other_errors++;
            decoded_q.delete();
        end
    endtask

    // en drops halfway through a frame while two bytes wait in the FIFO
    task automatic run_disable_test();
        int v0;
        int f0;
        tx_pause = 1'b1;
        repeat (2) receive_frame("disable hold", uart_byte_t'($urandom), 1'b0);
        v0 = valid_cnt;
        f0 = ferr_cnt;
        fork
            send_frame(uart_byte_t'($urandom), 1'b0);
            begin
                repeat (4 * (int'(comp) + 1) + 3) @(negedge clk);
                en = 1'b0;
            end
        join
        check_flag("disable rx_valid", 1'b0, valid_cnt != v0);
        check_flag("disable frame_err", 1'b0, ferr_cnt != f0);
        echo_q.delete();    // flushed with the FIFO
        rx_q.delete();
        held = 0;
        tx_pause = 1'b0;
        repeat (4) @(negedge clk);
        en = 1'b1;
        drain_echo("disable flush");
        receive_frame("disable resume", uart_byte_t'($urandom), 1'b0);
        drain_echo("disable resume echo");
    endtask

    initial
    begin
        void'($urandom(6));
        resetn   = 1'b0;
        en       = 1'b0;
        tx_pause = 1'b0;
        comp     = baud_div_t'(15);
        uart_rx  = 1'b1;
        repeat (8) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        check_flag("reset uart_tx", 1'b1, uart_tx);
        check_flag("reset rx_valid", 1'b0, rx_valid);
        check_flag("reset frame_err", 1'b0, frame_err);
        check_flag("reset overflow", 1'b0, overflow);
        en = 1'b1;
        @(negedge clk);

        repeat (30) receive_frame("receive comp 15", uart_byte_t'($urandom), 1'b0);
        drain_echo("echo comp 15");
        comp = baud_div_t'(8 + $urandom % 33);      // 8 to 40
        repeat (30) receive_frame("receive random comp", uart_byte_t'($urandom), 1'b0);
        drain_echo("echo random comp");

        repeat (6) receive_frame("framing", uart_byte_t'($urandom), 1'b1);
        drain_echo("framing echo");

        tx_pause = 1'b1;
        repeat (11) receive_frame("overflow", uart_byte_t'($urandom), 1'b0);
        tx_pause = 1'b0;
        held = 0;
        drain_echo("overflow echo");

        run_disable_test();

        $display("errors: %0d mismatches, %0d other failures",
                 mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule : uart_echo_tb

//--- vlog.f
+incdir+verification
logic/uart_line_pkg.sv
logic/uart_buf_pkg.sv
logic/uart_receiver.sv
logic/byte_fifo.sv
logic/uart_transmitter.sv
logic/uart_echo.sv
verification/uart_echo_tb.sv
